/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := branch_predictor_tb
FILELIST := branch_predictor.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(wildcard hw/*.sv verification/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)

/* branch_predictor.f */
hw/bp_pkg.sv
hw/tagged_table.sv
hw/global_history.sv
hw/predict_control.sv
hw/branch_predictor.sv
verification/branch_predictor_assert.sv
verification/branch_predictor_tb.sv

/* hw/bp_pkg.sv */
`default_nettype none

package bp_pkg;

	// full program counter width.
	localparam int pc_width = 64;

	// 2-bit saturating direction counter, upper bit is the direction.
	typedef logic [1:0] counter_t;

	localparam counter_t ctr_strong_not_taken = 2'd0;
	localparam counter_t ctr_weak_not_taken   = 2'd1;
	localparam counter_t ctr_weak_taken       = 2'd2;
	localparam counter_t ctr_strong_taken     = 2'd3;

	// targets are 4-byte aligned, so only the word address is stored.
	localparam int target_bits = pc_width - 2;

	typedef logic [target_bits-1:0] target_t;

endpackage : bp_pkg

`default_nettype wire

/* hw/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

// tagged gshare branch predictor, same-cycle lookup, trained on resolve.
module branch_predictor
	import bp_pkg::*;
#(
	parameter int index_bits = 8,
	parameter int history_bits = 8,
	localparam int tag_bits = pc_width - 2 - index_bits
) (
	input  wire logic                clk,
	input  wire logic                reset,

	input  wire logic                lookup_valid,
	input  wire logic [pc_width-1:0] lookup_pc,
	output logic                     prediction_hit,
	output logic                     prediction_taken,
	output logic      [pc_width-1:0] prediction_target,

	input  wire logic                resolve_valid,
	input  wire logic [pc_width-1:0] resolve_pc,
	input  wire logic                resolve_taken,
	input  wire logic [pc_width-1:0] resolve_target
);

	logic [index_bits-1:0] lookup_index;
	logic [tag_bits-1:0]   lookup_tag;
	logic [index_bits-1:0] resolve_index;
	logic [tag_bits-1:0]   resolve_tag;

	logic [index_bits-1:0] read_index;
	logic [tag_bits-1:0]   read_tag;
	logic [index_bits-1:0] check_index;
	logic [tag_bits-1:0]   check_tag;

	logic     history_shift;
	logic     history_taken;

	logic     ctr_read_hit;
	counter_t ctr_read_payload;
	logic     ctr_check_hit;
	counter_t ctr_check_payload;
	logic     ctr_write_enable;
	counter_t ctr_write_payload;

	logic     tgt_read_hit;
	target_t  tgt_read_payload;
	logic     tgt_write_enable;
	target_t  tgt_write_payload;

	global_history #(
		.index_bits   (index_bits),
		.history_bits (history_bits)
	) history_inst (
		.clk           (clk),
		.reset         (reset),
		.history_shift (history_shift),
		.history_taken (history_taken),
		.lookup_pc     (lookup_pc),
		.resolve_pc    (resolve_pc),
		.lookup_index  (lookup_index),
		.lookup_tag    (lookup_tag),
		.resolve_index (resolve_index),
		.resolve_tag   (resolve_tag)
	);

	predict_control #(
		.index_bits (index_bits)
	) control_inst (
		.lookup_valid      (lookup_valid),
		.lookup_pc         (lookup_pc),
		.lookup_index      (lookup_index),
		.lookup_tag        (lookup_tag),
		.resolve_valid     (resolve_valid),
		.resolve_taken     (resolve_taken),
		.resolve_target    (resolve_target),
		.resolve_index     (resolve_index),
		.resolve_tag       (resolve_tag),
		.read_index        (read_index),
		.read_tag          (read_tag),
		.check_index       (check_index),
		.check_tag         (check_tag),
		.ctr_read_hit      (ctr_read_hit),
		.ctr_read_payload  (ctr_read_payload),
		.ctr_check_hit     (ctr_check_hit),
		.ctr_check_payload (ctr_check_payload),
		.tgt_read_hit      (tgt_read_hit),
		.tgt_read_payload  (tgt_read_payload),
		.ctr_write_enable  (ctr_write_enable),
		.ctr_write_payload (ctr_write_payload),
		.tgt_write_enable  (tgt_write_enable),
		.tgt_write_payload (tgt_write_payload),
		.history_shift     (history_shift),
		.history_taken     (history_taken),
		.prediction_hit    (prediction_hit),
		.prediction_taken  (prediction_taken),
		.prediction_target (prediction_target)
	);

	// direction counters.
	tagged_table #(
		.index_bits    (index_bits),
		.payload_t     (counter_t),
		.reset_payload (ctr_strong_not_taken)
	) ctr_table (
		.clk           (clk),
		.reset         (reset),
		.read_index    (read_index),
		.read_tag      (read_tag),
		.read_hit      (ctr_read_hit),
		.read_payload  (ctr_read_payload),
		.check_index   (check_index),
		.check_tag     (check_tag),
		.check_hit     (ctr_check_hit),
		.check_payload (ctr_check_payload),
		.write_enable  (ctr_write_enable),
		.write_index   (resolve_index),
		.write_tag     (resolve_tag),
		.write_payload (ctr_write_payload)
	);

	// branch targets, the check port is not needed here.
	tagged_table #(
		.index_bits    (index_bits),
		.payload_t     (target_t),
		.reset_payload ('0)
	) tgt_table (
		.clk           (clk),
		.reset         (reset),
		.read_index    (read_index),
		.read_tag      (read_tag),
		.read_hit      (tgt_read_hit),
		.read_payload  (tgt_read_payload),
		.check_index   (check_index),
		.check_tag     (check_tag),
		.check_hit     (),
		.check_payload (),
		.write_enable  (tgt_write_enable),
		.write_index   (resolve_index),
		.write_tag     (resolve_tag),
		.write_payload (tgt_write_payload)
	);

endmodule : branch_predictor

`default_nettype wire

/* hw/global_history.sv */
`timescale 1ns/10ps
`default_nettype none

// global outcome history and the gshare hash for both pcs.
module global_history
	import bp_pkg::*;
#(
	parameter int index_bits = 8,
	parameter int history_bits = 8,
	localparam int tag_bits = pc_width - 2 - index_bits
) (
	input  wire logic                  clk,
	input  wire logic                  reset,

	input  wire logic                  history_shift,
	input  wire logic                  history_taken,

	input  wire logic [pc_width-1:0]   lookup_pc,
	input  wire logic [pc_width-1:0]   resolve_pc,

	output logic      [index_bits-1:0] lookup_index,
	output logic      [tag_bits-1:0]   lookup_tag,
	output logic      [index_bits-1:0] resolve_index,
	output logic      [tag_bits-1:0]   resolve_tag
);

	logic [history_bits-1:0] history; // newest outcome in bit 0.
	logic [index_bits-1:0]   history_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			history <= '0;
		end else if (history_shift) begin
			history <= (history << 1) | history_bits'(history_taken);
		end
	end

	// short histories only fold into the low index bits.
	assign history_ext = index_bits'(history);

	// word-index bits of the pc xor history.
	assign lookup_index  = lookup_pc[index_bits+1:2] ^ history_ext;
	assign resolve_index = resolve_pc[index_bits+1:2] ^ history_ext;

	// everything above the index is tag.
	assign lookup_tag  = lookup_pc[pc_width-1:index_bits+2];
	assign resolve_tag = resolve_pc[pc_width-1:index_bits+2];

endmodule : global_history

`default_nettype wire

/* hw/predict_control.sv */
`timescale 1ns/10ps
`default_nettype none

// turns lookups into predictions and resolves into table training.
// this block is purely combinational and the tables and history register the writes.
module predict_control
	import bp_pkg::*;
#(
	parameter int index_bits = 8,
	localparam int tag_bits = pc_width - 2 - index_bits
) (
	input  wire logic                  lookup_valid,
	input  wire logic [pc_width-1:0]   lookup_pc,
	input  wire logic [index_bits-1:0] lookup_index,
	input  wire logic [tag_bits-1:0]   lookup_tag,

	input  wire logic                  resolve_valid,
	input  wire logic                  resolve_taken,
	input  wire logic [pc_width-1:0]   resolve_target,
	input  wire logic [index_bits-1:0] resolve_index,
	input  wire logic [tag_bits-1:0]   resolve_tag,

	// table read and check addressing.
	output logic      [index_bits-1:0] read_index,
	output logic      [tag_bits-1:0]   read_tag,
	output logic      [index_bits-1:0] check_index,
	output logic      [tag_bits-1:0]   check_tag,

	input  wire logic                  ctr_read_hit,
	input  wire counter_t              ctr_read_payload,
	input  wire logic                  ctr_check_hit,
	input  wire counter_t              ctr_check_payload,
	input  wire logic                  tgt_read_hit,
	input  wire target_t               tgt_read_payload,

	output logic                       ctr_write_enable,
	output counter_t                   ctr_write_payload,
	output logic                       tgt_write_enable,
	output target_t                    tgt_write_payload,

	output logic                       history_shift,
	output logic                       history_taken,

	output logic                       prediction_hit,
	output logic                       prediction_taken,
	output logic      [pc_width-1:0]   prediction_target
);

	logic [pc_width-1:0] fall_through; // sequential next fetch.

	// both tables share the hashed index and tag.
	assign read_index  = lookup_index;
	assign read_tag    = lookup_tag;
	assign check_index = resolve_index;
	assign check_tag   = resolve_tag;

	assign fall_through = lookup_pc + pc_width'(4);

	// prediction side.
	always_comb begin
		prediction_hit    = lookup_valid && ctr_read_hit;
		prediction_taken  = prediction_hit && ctr_read_payload[1]; // upper bit is direction.
		prediction_target = '0;
		if (lookup_valid) begin
			// a taken guess without a stored target still falls through.
			if (prediction_taken && tgt_read_hit) begin
				prediction_target = {tgt_read_payload, 2'b00};
			end else begin
				prediction_target = fall_through;
			end
		end
	end

	// counter training.
	always_comb begin
		ctr_write_enable = resolve_valid;
		if (!ctr_check_hit) begin
			// new entry starts weak in the resolved direction.
			ctr_write_payload = resolve_taken ? ctr_weak_taken : ctr_weak_not_taken;
		end else if (resolve_taken) begin
			if (ctr_check_payload == ctr_strong_taken) begin
				ctr_write_payload = ctr_strong_taken; // saturate at the top.
			end else begin
				ctr_write_payload = ctr_check_payload + counter_t'(1);
			end
		end else begin
			if (ctr_check_payload == ctr_strong_not_taken) begin
				ctr_write_payload = ctr_strong_not_taken; // saturate at the bottom.
			end else begin
				ctr_write_payload = ctr_check_payload - counter_t'(1);
			end
		end
	end

	// only taken branches have a target worth keeping.
	assign tgt_write_enable  = resolve_valid && resolve_taken;
	assign tgt_write_payload = resolve_target[pc_width-1:2];

	// every resolved branch moves the history.
	assign history_shift = resolve_valid;
	assign history_taken = resolve_taken;

endmodule : predict_control

`default_nettype wire

/* hw/tagged_table.sv */
`timescale 1ns/10ps
`default_nettype none

// direct-mapped array of valid, tag and payload per entry.
// the read port serves lookups and the check port lets training see the old entry.
module tagged_table
	import bp_pkg::*;
#(
	parameter int index_bits = 8,
	parameter type payload_t = logic [1:0],
	parameter payload_t reset_payload = payload_t'(0),
	localparam int tag_bits = pc_width - 2 - index_bits
) (
	input  wire logic                  clk,
	input  wire logic                  reset,

	input  wire logic [index_bits-1:0] read_index,
	input  wire logic [tag_bits-1:0]   read_tag,
	output logic                       read_hit,
	output payload_t                   read_payload,

	input  wire logic [index_bits-1:0] check_index,
	input  wire logic [tag_bits-1:0]   check_tag,
	output logic                       check_hit,
	output payload_t                   check_payload,

	input  wire logic                  write_enable,
	input  wire logic [index_bits-1:0] write_index,
	input  wire logic [tag_bits-1:0]   write_tag,
	input  wire payload_t              write_payload
);

	localparam int depth = 1 << index_bits;

	logic                valid    [depth]; // entry holds a live branch.
	logic [tag_bits-1:0] tags     [depth];
	payload_t            payloads [depth];

	// reset empties every entry at once.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				valid[i] <= 1'b0;
			end
		end else if (write_enable) begin
			valid[write_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (write_enable) begin
			tags[write_index]     <= write_tag;
			payloads[write_index] <= write_payload;
		end
	end

	// the lookup side sees the contents from before this edge.
	always_comb begin
		read_hit = valid[read_index] && (tags[read_index] == read_tag);
		if (read_hit) begin
			read_payload = payloads[read_index];
		end else begin
			read_payload = reset_payload; // miss reads as the idle value.
		end
	end

	// resolve side.
	always_comb begin
		check_hit = valid[check_index] && (tags[check_index] == check_tag);
		if (check_hit) begin
			check_payload = payloads[check_index];
		end else begin
			check_payload = reset_payload;
		end
	end

endmodule : tagged_table

`default_nettype wire

/* verification/branch_predictor_assert.sv */
`timescale 1ns/10ps
`default_nettype none

// output consistency checks, bound into the predictor top level.
module branch_predictor_assert
	import bp_pkg::*;
(
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                lookup_valid,
	input  wire logic [pc_width-1:0] lookup_pc,
	input  wire logic                prediction_hit,
	input  wire logic                prediction_taken,
	input  wire logic [pc_width-1:0] prediction_target
);

	// a taken prediction needs a matching entry.
	taken_needs_hit: assert property (@(posedge clk) disable iff (reset)
		prediction_taken |-> prediction_hit)
		else $error("prediction_taken is set without prediction_hit");

	// stored targets and fall-through keep the pc alignment.
	target_alignment: assert property (@(posedge clk) disable iff (reset)
		lookup_valid |-> (prediction_target[1:0] == lookup_pc[1:0]))
		else $error("low bits of prediction_target differ from lookup_pc");

	idle_outputs: assert property (@(posedge clk) disable iff (reset)
		!lookup_valid |-> (!prediction_hit && !prediction_taken))
		else $error("hit or taken is set while no lookup is driven");

endmodule : branch_predictor_assert

bind branch_predictor branch_predictor_assert branch_predictor_assert_inst (
	.clk               (clk),
	.reset             (reset),
	.lookup_valid      (lookup_valid),
	.lookup_pc         (lookup_pc),
	.prediction_hit    (prediction_hit),
	.prediction_taken  (prediction_taken),
	.prediction_target (prediction_target)
);

`default_nettype wire

/* verification/branch_predictor_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_tb
	import bp_pkg::*;
();

	localparam int index_bits   = 8;
	localparam int history_bits = 8;
	localparam int tag_bits     = pc_width - 2 - index_bits;
	localparam int depth        = 1 << index_bits;
	localparam int reset_limit  = 20; // cycles allowed for reset release.

	logic                clk;
	logic                reset;
	logic                lookup_valid;
	logic [pc_width-1:0] lookup_pc;
	logic                prediction_hit;
	logic                prediction_taken;
	logic [pc_width-1:0] prediction_target;
	logic                resolve_valid;
	logic [pc_width-1:0] resolve_pc;
	logic                resolve_taken;
	logic [pc_width-1:0] resolve_target;

	// reference model state.
	logic                    ref_ctr_valid [depth];
	logic [tag_bits-1:0]     ref_ctr_tag   [depth];
	logic [1:0]              ref_ctr       [depth];
	logic                    ref_tgt_valid [depth];
	logic [tag_bits-1:0]     ref_tgt_tag   [depth];
	logic [pc_width-3:0]     ref_tgt_word  [depth];
	logic [history_bits-1:0] ref_history;

	int   seed;
	int   tests;
	int   checks;
	int   errors;
	logic reset_released;

	branch_predictor branch_predictor_inst (
		.clk               (clk),
		.reset             (reset),
		.lookup_valid      (lookup_valid),
		.lookup_pc         (lookup_pc),
		.prediction_hit    (prediction_hit),
		.prediction_taken  (prediction_taken),
		.prediction_target (prediction_target),
		.resolve_valid     (resolve_valid),
		.resolve_pc        (resolve_pc),
		.resolve_taken     (resolve_taken),
		.resolve_target    (resolve_target)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// gshare index from the word bits and the model history.
	function automatic logic [index_bits-1:0] hash_index(input logic [pc_width-1:0] pc);
		return pc[index_bits+1:2] ^ index_bits'(ref_history);
	endfunction

	// expected {hit, taken, target} for a lookup against the model.
	function automatic logic [pc_width+1:0] predict_expected(input logic valid,
			input logic [pc_width-1:0] pc);
		logic [index_bits-1:0] idx;
		logic [tag_bits-1:0]   tag;
		logic                  hit;
		logic                  taken;
		logic [pc_width-1:0]   target;
		idx = hash_index(pc);
		tag = pc[pc_width-1:index_bits+2];
		hit = valid && ref_ctr_valid[idx] && (ref_ctr_tag[idx] == tag);
		taken = hit && ref_ctr[idx][1];
		if (!valid) begin
			target = '0;
		end else if (taken && ref_tgt_valid[idx] && (ref_tgt_tag[idx] == tag)) begin
			target = {ref_tgt_word[idx], 2'b00};
		end else begin
			target = pc + 64'd4;
		end
		return {hit, taken, target};
	endfunction

	// model training reads the inputs as they stood before this edge.
	always @(posedge clk) begin : apply_resolve
		logic [index_bits-1:0] idx;
		logic [tag_bits-1:0]   tag;
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				ref_ctr_valid[i] = 1'b0;
				ref_tgt_valid[i] = 1'b0;
			end
			ref_history = '0;
		end else if (resolve_valid) begin
			idx = hash_index(resolve_pc);
			tag = resolve_pc[pc_width-1:index_bits+2];
			if (ref_ctr_valid[idx] && (ref_ctr_tag[idx] == tag)) begin
				if (resolve_taken && (ref_ctr[idx] != 2'd3)) begin
					ref_ctr[idx] = ref_ctr[idx] + 2'd1;
				end else if (!resolve_taken && (ref_ctr[idx] != 2'd0)) begin
					ref_ctr[idx] = ref_ctr[idx] - 2'd1;
				end
			end else begin
				ref_ctr_valid[idx] = 1'b1; // allocate weak in the resolved direction.
				ref_ctr_tag[idx]   = tag;
				ref_ctr[idx]       = resolve_taken ? 2'd2 : 2'd1;
			end
			if (resolve_taken) begin
				ref_tgt_valid[idx] = 1'b1;
				ref_tgt_tag[idx]   = tag;
				ref_tgt_word[idx]  = resolve_target[pc_width-1:2];
			end
			ref_history = {ref_history[history_bits-2:0], resolve_taken};
		end
	end

	// outputs are settled by the falling edge.
	always @(negedge clk) begin : compare_outputs
		logic [pc_width+1:0] expected;
		if (!reset) begin
			expected = predict_expected(lookup_valid, lookup_pc);
			checks++;
			assert ({prediction_hit, prediction_taken, prediction_target} === expected)
			else begin
				$display("error %0t: model mismatch at pc %h, got %b %b %h, expected %b %b %h",
					$time, lookup_pc, prediction_hit, prediction_taken, prediction_target,
					expected[pc_width+1], expected[pc_width], expected[pc_width-1:0]);
				errors++;
			end
		end
	end

	function automatic logic [pc_width-1:0] random_aligned_pc();
		logic [31:0] upper;
		logic [31:0] lower;
		upper = $random(seed);
		lower = $random(seed);
		return {upper, lower[31:2], 2'b00};
	endfunction

	task automatic drive_cycle(input logic lv, input logic [pc_width-1:0] lpc,
			input logic rv, input logic [pc_width-1:0] rpc, input logic rtaken,
			input logic [pc_width-1:0] rtarget);
		@(posedge clk);
		lookup_valid   <= lv;
		lookup_pc      <= lpc;
		resolve_valid  <= rv;
		resolve_pc     <= rpc;
		resolve_taken  <= rtaken;
		resolve_target <= rtarget;
	endtask

	task automatic drive_resolve(input logic [pc_width-1:0] pc, input logic taken,
			input logic [pc_width-1:0] target);
		drive_cycle(1'b0, '0, 1'b1, pc, taken, target);
	endtask

	// lookup with the expected answer worked out by the caller.
	task automatic expect_lookup(input logic [pc_width-1:0] pc, input logic hit,
			input logic taken, input logic [pc_width-1:0] target);
		drive_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0);
		@(negedge clk);
		checks++;
		assert (prediction_hit === hit && prediction_taken === taken
			&& prediction_target === target)
		else begin
			$display("error %0t: lookup at pc %h gave %b %b %h, expected %b %b %h",
				$time, pc, prediction_hit, prediction_taken, prediction_target,
				hit, taken, target);
			errors++;
		end
	endtask

	// a run of equal outcomes leaves the history all ones or all zeros.
	task automatic set_history(input logic [pc_width-1:0] filler_pc, input logic taken);
		for (int i = 0; i < history_bits; i++) begin
			drive_resolve(filler_pc, taken, filler_pc + 64'h100);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic wait_reset_release(output logic released);
		int cycles;
		cycles = 0;
		while (reset && (cycles < reset_limit)) begin
			@(negedge clk);
			cycles++;
		end
		released = !reset;
	endtask

	task automatic check_reset_state();
		int                  errors_before;
		logic [pc_width-1:0] pc;
		errors_before = errors;
		for (int i = 0; i < 16; i++) begin
			pc = random_aligned_pc();
			expect_lookup(pc, 1'b0, 1'b0, pc + 64'd4);
		end
		finish_test("reset_state", errors_before);
	endtask

	task automatic check_first_resolve();
		int                  errors_before;
		logic [pc_width-1:0] taken_pc;
		logic [pc_width-1:0] not_taken_pc;
		errors_before = errors;
		taken_pc     = 64'h0000_0000_0040_1230;
		not_taken_pc = 64'h0000_0000_0000_5678;
		set_history(taken_pc ^ (64'h1 << 20), 1'b1);
		drive_resolve(taken_pc, 1'b1, 64'h0000_0000_0040_2000);
		expect_lookup(taken_pc, 1'b1, 1'b1, 64'h0000_0000_0040_2000);
		set_history(not_taken_pc ^ (64'h1 << 30), 1'b0);
		drive_resolve(not_taken_pc, 1'b0, 64'h0000_0000_0000_9000);
		expect_lookup(not_taken_pc, 1'b1, 1'b0, not_taken_pc + 64'd4);
		finish_test("first_resolve", errors_before);
	endtask

	task automatic check_saturation();
		int                  errors_before;
		logic [pc_width-1:0] pc;
		logic [pc_width-1:0] target;
		errors_before = errors;
		pc     = 64'h0000_0000_0080_0a40;
		target = 64'h0000_0000_0080_4000;
		set_history(pc ^ (64'h1 << 40), 1'b1);
		for (int i = 0; i < 3; i++) begin
			drive_resolve(pc, 1'b1, target);
		end
		drive_resolve(pc, 1'b0, target);
		set_history(pc ^ (64'h1 << 40), 1'b1); // back to the same index.
		expect_lookup(pc, 1'b1, 1'b1, target);
		finish_test("saturation", errors_before);
	endtask

	task automatic check_aliasing();
		int                  errors_before;
		logic [pc_width-1:0] first_pc;
		logic [pc_width-1:0] second_pc;
		errors_before = errors;
		first_pc  = 64'h0000_0000_0000_3300;
		second_pc = first_pc ^ (64'h1 << 33); // same index with another tag.
		set_history(first_pc ^ (64'h1 << 50), 1'b1);
		drive_resolve(first_pc, 1'b1, 64'h0000_0000_0000_7000);
		expect_lookup(first_pc, 1'b1, 1'b1, 64'h0000_0000_0000_7000);
		drive_resolve(second_pc, 1'b1, 64'h0000_0000_0000_8000);
		expect_lookup(first_pc, 1'b0, 1'b0, first_pc + 64'd4);
		expect_lookup(second_pc, 1'b1, 1'b1, 64'h0000_0000_0000_8000);
		finish_test("aliasing", errors_before);
	endtask

	task automatic run_random(input int cycles);
		int                  errors_before;
		logic [pc_width-1:0] pool [8];
		logic                lv;
		logic                rv;
		logic                rtaken;
		int                  lsel;
		int                  rsel;
		logic [pc_width-1:0] rtarget;
		errors_before = errors;
		for (int i = 0; i < 4; i++) begin
			pool[i]     = random_aligned_pc();
			pool[i + 4] = pool[i] ^ (64'h1 << (20 + i));
		end
		for (int n = 0; n < cycles; n++) begin
			lv      = ($random(seed) & 3) != 0;
			lsel    = $random(seed) & 7;
			rv      = ($random(seed) & 1) == 1;
			rsel    = $random(seed) & 7;
			rtaken  = ($random(seed) & 1) == 1;
			rtarget = random_aligned_pc();
			drive_cycle(lv, pool[lsel], rv, pool[rsel], rtaken, rtarget);
		end
		finish_test("random_traffic", errors_before);
	endtask

	initial begin
		seed           = 32'h7daa;
		tests          = 0;
		checks         = 0;
		errors         = 0;
		reset          = 1'b1;
		lookup_valid   = 1'b0;
		lookup_pc      = '0;
		resolve_valid  = 1'b0;
		resolve_pc     = '0;
		resolve_taken  = 1'b0;
		resolve_target = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		wait_reset_release(reset_released);
		if (reset_released) begin
			check_reset_state();
			check_first_resolve();
			check_saturation();
			check_aliasing();
			run_random(2000);
			drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
			@(negedge clk);
			$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
			if (errors == 0) begin
				$display("NO ERRORS");
			end else begin
				$display("ERRORS FOUND");
			end
		end else begin
			$display("timeout: reset was still asserted after %0d cycles", reset_limit);
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule : branch_predictor_tb

`default_nettype wire
